// File: build.f
elevator_pkg.sv
request_latch.sv
car_control.sv
floor_logic_top.sv
tb_floor_logic.sv

// File: car_control.sv
// Car control
// Picks the next target floor from the lit lamps, preferring the travel
// direction, asks the motion FSM to move, and passes door requests

`timescale 1ns/1ps

module car_control (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t call_button_lights,
    input  elevator_pkg::floor_mask_t panel_button_lights,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      elevator_moving,
    input  logic                      elevator_direction,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    output elevator_pkg::floor_t      target_floor,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    import elevator_pkg::*;

    floor_mask_t pending;
    floor_t      above_floor;
    floor_t      below_floor;
    logic        above_found;
    logic        below_found;
    floor_t      next_target;
    logic        enabled;
    logic        at_target;
    logic        door_gate;

    // A floor is pending if either of its lamps is on
    assign pending = call_button_lights | panel_button_lights;

    assign enabled   = power_switch && !emergency_btn;
    assign at_target = !elevator_moving && (target_floor == current_floor);
    assign door_gate = !elevator_moving && power_switch;

    //////////////////////////////////////////////////////////////////////
    // Pending floor scans
    //////////////////////////////////////////////////////////////////////

    // Nearest lit floor above the car, scanned top down so the lowest wins
    always_comb begin
        above_floor = floor_none;
        for (int i = int'(floor_last); i >= int'(floor_first); i--) begin
            if (pending[i] && (floor_t'(i) > current_floor)) begin
                above_floor = floor_t'(i);
            end
        end
    end

    // Nearest lit floor below the car, scanned bottom up so the highest wins
    always_comb begin
        below_floor = floor_none;
        for (int i = int'(floor_first); i <= int'(floor_last); i++) begin
            if (pending[i] && (floor_t'(i) < current_floor)) begin
                below_floor = floor_t'(i);
            end
        end
    end

    assign above_found = (above_floor != floor_none);
    assign below_found = (below_floor != floor_none);

    //////////////////////////////////////////////////////////////////////
    // Target selection
    //////////////////////////////////////////////////////////////////////

    // Keep going the preferred way, turn around only when nothing is left
    always_comb begin
        if (elevator_direction) begin
            if (above_found) begin
                next_target = above_floor;
            end else if (below_found) begin
                next_target = below_floor;
            end else begin
                next_target = current_floor;
            end
        end else begin
            if (below_found) begin
                next_target = below_floor;
            end else if (above_found) begin
                next_target = above_floor;
            end else begin
                next_target = current_floor;
            end
        end
    end

    // New target only once the car rests at the old one
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= floor_first;
        end else if (at_target) begin
            target_floor <= next_target;
        end
    end

    // Motion request to the FSM
    assign activate_elevator = enabled && !elevator_moving && (target_floor != current_floor);

    // Up is the idle default, down only while the target lies below
    assign direction_selector = !(target_floor < current_floor);

    //////////////////////////////////////////////////////////////////////
    // Door permits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else if (door_gate) begin
            door_open_allowed  <= door_open_btn;
            door_close_allowed <= door_close_btn;
        end else begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end
    end

endmodule

// File: elevator_pkg.sv
// Elevator floor request package
// Floor count, floor index and mask types, and the reserved floor code
// shared by the request latch and the car control

package elevator_pkg;

    //////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////

    // Floors served by the car, floor 1 is index 0
    localparam int num_floors = 11;

    // Bits needed to hold a floor index
    localparam int floor_bits = 4;

    //////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////

    // Floor index, 0 up to num_floors-1
    typedef logic [floor_bits-1:0] floor_t;

    // One bit per floor, bit i stands for floor index i
    // Used for the hall calls, the car panel and both lamp banks
    typedef logic [num_floors-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////
    // Floor codes
    //////////////////////////////////////////////////////////////////

    // Lowest and highest served floor
    localparam floor_t floor_first = floor_t'(0);
    localparam floor_t floor_last  = floor_t'(num_floors - 1);

    // Codes above floor_last never name a floor
    // The top code marks a scan that found no lit floor
    localparam floor_t floor_none  = 4'hF;

endpackage

// File: floor_logic_top.sv
// Elevator floor logic top level
// Request latch feeding the car control, all signals as plain ports

`timescale 1ns/1ps

module floor_logic_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      elevator_moving,
    input  logic                      elevator_direction,
    output elevator_pkg::floor_t      target_floor,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights
);

    // Lamps are both outputs and the request source for the car control
    request_latch request_latch0 (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .elevator_moving     (elevator_moving),
        .current_floor       (current_floor),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    car_control car_control0 (
        .clock               (clock),
        .reset_n             (reset_n),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .elevator_direction  (elevator_direction),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .target_floor        (target_floor),
        .direction_selector  (direction_selector),
        .activate_elevator   (activate_elevator),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed)
    );

endmodule

// File: request_latch.sv
// Floor request latch
// Holds the hall call and car panel lamps. Presses set lamps while the car
// is enabled, and a stop at a floor clears both lamps of that floor.

`timescale 1ns/1ps

module request_latch (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  logic                      elevator_moving,
    input  elevator_pkg::floor_t      current_floor,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights
);

    import elevator_pkg::*;

    logic        enabled;
    logic        stopped;
    floor_mask_t here_mask;
    floor_mask_t call_set;
    floor_mask_t panel_set;
    floor_mask_t clear_mask;
    floor_mask_t call_next;
    floor_mask_t panel_next;

    // Car accepts new requests only with power on and no emergency
    assign enabled = power_switch && !emergency_btn;

    // Stopped and powered, the car serves the floor it is at
    assign stopped = power_switch && !elevator_moving;

    //////////////////////////////////////////////////////////////////////
    // Current floor decode
    //////////////////////////////////////////////////////////////////////

    // One-hot of the current floor, all zero for a code past floor_last
    always_comb begin
        here_mask = '0;
        for (int i = 0; i < num_floors; i++) begin
            if (current_floor == floor_t'(i)) begin
                here_mask[i] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Set and clear masks
    //////////////////////////////////////////////////////////////////////

    // Every pressed button latches at once, except the one for this floor
    assign call_set  = enabled ? (floor_call_buttons & ~here_mask) : '0;
    assign panel_set = enabled ? (panel_buttons & ~here_mask) : '0;

    // Arrival wins over a set for the same floor
    assign clear_mask = stopped ? here_mask : '0;

    assign call_next  = (call_button_lights | call_set) & ~clear_mask;
    assign panel_next = (panel_button_lights | panel_set) & ~clear_mask;

    //////////////////////////////////////////////////////////////////////
    // Lamp registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            call_button_lights  <= call_next;
            panel_button_lights <= panel_next;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the floor logic testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing -f build.f --top-module tb_floor_logic -o sim_floor_logic \
    && ./obj_dir/sim_floor_logic > sim.log 2>&1 \
    || echo "Build or run error"

cat sim.log 2>/dev/null

grep -q "Simulation passed" sim.log && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }

// File: tb_floor_logic.sv
// Floor logic testbench
// Directed tests of lamp latching, target selection, activation, arrival
// and door permits, checked against a model of the selection rule

`timescale 1ns/1ps

module tb_floor_logic;

    import elevator_pkg::*;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        elevator_moving;
    logic        elevator_direction;
    floor_t      target_floor;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rand_state;
    floor_t      exp_target;

    floor_logic_top dut0 (.*);

    always #2 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Random numbers and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Nearest lit floor in the preferred direction, else the other way
    function automatic floor_t expected_target(input floor_mask_t call_m,
                                               input floor_mask_t panel_m,
                                               input floor_t cur, input logic up_pref);
        floor_mask_t lit;
        logic        up_found;
        logic        down_found;
        floor_t      up_floor;
        floor_t      down_floor;
        lit = call_m | panel_m;
        up_found = 1'b0;
        down_found = 1'b0;
        up_floor = cur;
        down_floor = cur;
        for (int i = int'(cur) + 1; i < num_floors; i++) begin
            if (lit[i] && !up_found) begin
                up_found = 1'b1;
                up_floor = floor_t'(i);
            end
        end
        for (int i = int'(cur) - 1; i >= 0; i--) begin
            if (lit[i] && !down_found) begin
                down_found = 1'b1;
                down_floor = floor_t'(i);
            end
        end
        if (up_pref) begin
            return up_found ? up_floor : (down_found ? down_floor : cur);
        end
        return down_found ? down_floor : (up_found ? up_floor : cur);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task check_mask(input floor_mask_t got, input floor_mask_t exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task check_floor(input floor_t got, input floor_t exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task finish_test(input string name, input int start);
        if (errors == start) begin
            tests_passed++;
            $display("Test %s done, no errors", name);
        end else begin
            tests_failed++;
            $display("Test %s done, %0d errors", name, errors - start);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // Random presses, always at least one away from the given floor
    task press_random(input floor_t cur, output floor_mask_t call_m,
                      output floor_mask_t panel_m);
        floor_mask_t here;
        here = floor_mask_t'(1) << cur;
        rand_state = lcg_next(rand_state);
        call_m = rand_state[30:20];
        rand_state = lcg_next(rand_state);
        panel_m = rand_state[30:20];
        if (((call_m | panel_m) & ~here) == '0) begin
            panel_m[(int'(cur) + 1) % num_floors] = 1'b1;
        end
        floor_call_buttons <= call_m;
        panel_buttons <= panel_m;
    endtask

    task release_buttons;
        floor_call_buttons <= '0;
        panel_buttons <= '0;
    endtask

    task wait_for_activate(input logic level, input int limit);
        int n;
        n = 0;
        while (activate_elevator !== level && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (activate_elevator !== level) begin
            $display("Timeout: activate_elevator did not reach %b within %0d cycles",
                     level, limit);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task test_reset;
        int start;
        start = errors;
        @(negedge clock);
        check_mask(call_button_lights, '0, "call lamps after reset");
        check_mask(panel_button_lights, '0, "panel lamps after reset");
        check_bit(activate_elevator, 1'b0, "activate after reset");
        check_bit(door_open_allowed, 1'b0, "door open after reset");
        check_bit(door_close_allowed, 1'b0, "door close after reset");
        check_bit(direction_selector, 1'b1, "direction after reset");
        check_floor(target_floor, floor_first, "target after reset");
        finish_test("reset", start);
    endtask

    task test_latch;
        int          start;
        floor_t      cur;
        floor_mask_t here;
        floor_mask_t call_m;
        floor_mask_t panel_m;
        floor_mask_t old_call;
        floor_mask_t old_panel;
        start = errors;
        rand_state = lcg_next(rand_state);
        cur = floor_t'((rand_state >> 16) % 32'd11);
        here = floor_mask_t'(1) << cur;
        @(posedge clock);
        elevator_moving <= 1'b1;
        current_floor <= cur;
        @(posedge clock);
        @(negedge clock);
        old_call = call_button_lights;
        old_panel = panel_button_lights;
        @(posedge clock);
        press_random(cur, call_m, panel_m);
        @(posedge clock);
        release_buttons();
        @(negedge clock);
        check_mask(call_button_lights, old_call | (call_m & ~here), "call lamps after press");
        check_mask(panel_button_lights, old_panel | (panel_m & ~here), "panel lamps after press");
        // Emergency first, then power off
        for (int k = 0; k < 2; k++) begin
            old_call = call_button_lights;
            old_panel = panel_button_lights;
            @(posedge clock);
            if (k == 0) begin
                emergency_btn <= 1'b1;
            end else begin
                power_switch <= 1'b0;
            end
            press_random(cur, call_m, panel_m);
            @(posedge clock);
            release_buttons();
            emergency_btn <= 1'b0;
            power_switch <= 1'b1;
            @(negedge clock);
            check_mask(call_button_lights, old_call, "call lamps while disabled");
            check_mask(panel_button_lights, old_panel, "panel lamps while disabled");
        end
        finish_test("latch", start);
    endtask

    task test_select;
        int          start;
        floor_t      cur;
        floor_mask_t call_m;
        floor_mask_t panel_m;
        start = errors;
        // Directions alternate so later rounds start away from the bottom floor
        for (int r = 0; r < 4; r++) begin
            @(posedge clock);
            elevator_moving <= 1'b1;
            @(posedge clock);
            @(negedge clock);
            cur = target_floor;
            @(posedge clock);
            current_floor <= cur;
            press_random(cur, call_m, panel_m);
            @(posedge clock);
            release_buttons();
            elevator_moving <= 1'b0;
            elevator_direction <= r[0];
            @(negedge clock);
            exp_target = expected_target(call_button_lights, panel_button_lights, cur, r[0]);
            @(posedge clock);
            @(negedge clock);
            check_floor(target_floor, exp_target, "target after selection");
        end
        finish_test("select", start);
    endtask

    task test_activation;
        int     start;
        floor_t pos;
        start = errors;
        wait_for_activate(1'b1, 5);
        check_bit(direction_selector, exp_target > current_floor, "direction toward target");
        @(posedge clock);
        emergency_btn <= 1'b1;
        @(negedge clock);
        check_bit(activate_elevator, 1'b0, "activate with emergency");
        @(posedge clock);
        emergency_btn <= 1'b0;
        elevator_moving <= 1'b1;
        @(negedge clock);
        check_bit(activate_elevator, 1'b0, "activate while moving");
        // Direction seen from both ends of the shaft while the target holds
        for (int k = 0; k < 2; k++) begin
            pos = (k == 0) ? floor_first : floor_last;
            if (pos != exp_target) begin
                @(posedge clock);
                current_floor <= pos;
                @(negedge clock);
                check_bit(direction_selector, exp_target > pos, "direction from shaft end");
            end
        end
        finish_test("activation", start);
    endtask

    task test_arrival;
        int          start;
        floor_t      dest;
        floor_mask_t here;
        floor_mask_t old_call;
        floor_mask_t old_panel;
        start = errors;
        dest = exp_target;
        here = floor_mask_t'(1) << dest;
        @(posedge clock);
        current_floor <= dest;
        @(negedge clock);
        old_call = call_button_lights;
        old_panel = panel_button_lights;
        check_bit(|((old_call | old_panel) & here), 1'b1, "target lamp before arrival");
        @(posedge clock);
        elevator_moving <= 1'b0;
        @(negedge clock);
        exp_target = expected_target(old_call, old_panel, dest, elevator_direction);
        @(posedge clock);
        @(negedge clock);
        check_mask(call_button_lights, old_call & ~here, "call lamps after arrival");
        check_mask(panel_button_lights, old_panel & ~here, "panel lamps after arrival");
        check_floor(target_floor, exp_target, "next target after arrival");
        @(posedge clock);
        elevator_moving <= 1'b1;
        finish_test("arrival", start);
    endtask

    task test_doors;
        int start;
        start = errors;
        @(posedge clock);
        elevator_moving <= 1'b0;
        door_open_btn <= 1'b1;
        door_close_btn <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        check_bit(door_open_allowed, 1'b1, "door open while stopped");
        check_bit(door_close_allowed, 1'b0, "door close while stopped");
        @(posedge clock);
        door_open_btn <= 1'b0;
        door_close_btn <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_bit(door_open_allowed, 1'b0, "door open after release");
        check_bit(door_close_allowed, 1'b1, "door close while stopped");
        @(posedge clock);
        elevator_moving <= 1'b1;
        door_open_btn <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_bit(door_open_allowed, 1'b0, "door open while moving");
        check_bit(door_close_allowed, 1'b0, "door close while moving");
        @(posedge clock);
        door_open_btn <= 1'b0;
        door_close_btn <= 1'b0;
        finish_test("doors", start);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        rand_state = 32'h359b_b7ec;
        exp_target = floor_first;
        reset_n <= 1'b0;
        floor_call_buttons <= '0;
        panel_buttons <= '0;
        door_open_btn <= 1'b0;
        door_close_btn <= 1'b0;
        emergency_btn <= 1'b0;
        power_switch <= 1'b1;
        current_floor <= floor_first;
        elevator_moving <= 1'b0;
        elevator_direction <= 1'b1;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        test_reset();
        test_latch();
        test_select();
        test_activation();
        test_arrival();
        test_doors();
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
